/* filelist.f */
rtl/dcachePkg.sv
rtl/reqLatch.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/cacheCtrl.sv
rtl/busPort.sv
rtl/dcacheTop.sv
test/memModel.sv
test/tbDcache.sv

/* Makefile */
# Verilator build and run for the data cache testbench
VERILATOR ?= verilator
TOP       ?= tbDcache
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tbDcache.sv */
module tbDcache import dcachePkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IdleLimit = 400;

  logic   clk, rst_n, reqValid, addrOk, dataOk;
  cpuReqT req;
  wordT   rdData, memData;
  logic   rdReady, beatValid, rdLast, wbReady, rdValid, wbValid;
  addrT   rdAddr, wbAddr;
  lineT   wbLine;

  cpuReqT ops [$];
  int     cycle, opIdx, idle, wbTotal;
  logic   rdSeen, wbSeen;

  // reference cache and memory
  tagT    tagRef [2][NumSets];
  logic   validRef [2][NumSets];
  logic   dirtyRef [2][NumSets];
  lineT   lineRef [2][NumSets];
  logic   victimRef;
  wordT   memRef [addrT];

  // expected results in acceptance order
  logic   expIsLoad [$];
  logic   expHit [$];
  wordT   expWord [$];
  int     expAcc [$];
  addrT   expRdAddr [$];
  addrT   expWbAddr [$];
  lineT   expWbLine [$];

  dcacheTop dut_i (
    .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid), .req_i(req),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .rdReady_i(rdReady), .beatValid_i(beatValid), .rdData_i(memData),
    .rdLast_i(rdLast), .wbReady_i(wbReady), .rdValid_o(rdValid),
    .rdAddr_o(rdAddr), .wbValid_o(wbValid), .wbAddr_o(wbAddr), .wbLine_o(wbLine)
  );

  memModel memModel_i (
    .clk(clk), .rst_n(rst_n), .rdValid_i(rdValid), .rdAddr_i(rdAddr),
    .rdReady_o(rdReady), .beatValid_o(beatValid), .rdData_o(memData),
    .rdLast_o(rdLast), .wbValid_i(wbValid), .wbAddr_i(wbAddr),
    .wbLine_i(wbLine), .wbReady_o(wbReady)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic failValue(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic failPlain(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic checkWord(input string what, input wordT got, input wordT exp);
    if (got !== exp) begin
      failValue($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic checkAddr(input string what, input addrT got, input addrT exp);
    if (got !== exp) begin
      failValue($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic checkLine(input string what, input lineT got, input lineT exp);
    if (got !== exp) begin
      failValue($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      failValue($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  task automatic addOp(input logic wr, input addrT a, input wordT d, input maskT m);
    cpuReqT r;
    r.write = wr;
    r.addr  = a;
    r.wdata = d;
    r.mask  = m;
    ops.push_back(r);
  endtask

  // three tags share set 5 and one line sits in set 34
  task automatic buildTable();
    addOp(1'b0, 32'h0001_00a8, '0, 8'h00);
    addOp(1'b0, 32'h0001_00a8, '0, 8'h00);
    addOp(1'b0, 32'h0001_00a0, '0, 8'h00);
    addOp(1'b0, 32'h0001_00b0, '0, 8'h00);
    addOp(1'b0, 32'h0001_00b8, '0, 8'h00);
    addOp(1'b1, 32'h0001_00b3, 64'h0000_0000_00c3_b2a1, 8'h0b);
    addOp(1'b0, 32'h0001_00b0, '0, 8'h00);
    addOp(1'b1, 32'h0000_4c46, 64'h1122_3344_5566_7788, 8'hff);
    addOp(1'b0, 32'h0000_4c40, '0, 8'h00);
    addOp(1'b1, 32'h0002_00a8, 64'hdead_beef_cafe_f00d, 8'h3c);
    addOp(1'b0, 32'h0002_00a8, '0, 8'h00);
    addOp(1'b1, 32'h0003_00b8, 64'h0123_4567_89ab_cdef, 8'hff);
    addOp(1'b0, 32'h0001_00b0, '0, 8'h00);
    addOp(1'b0, 32'h0003_00b8, '0, 8'h00);
    addOp(1'b0, 32'h0002_00a8, '0, 8'h00);
    addOp(1'b0, 32'h0000_4c40, '0, 8'h00);
  endtask

  function automatic wordT refWord(addrT a);
    if (memRef.exists(a)) begin
      return memRef[a];
    end
    return {a, ~a};
  endfunction

  // byte i of the word takes data byte i-off where mask bit i-off is set
  function automatic wordT mergeStore(wordT old, wordT d, maskT m, logic [2:0] off);
    wordT res;
    int   src;
    res = old;
    for (int i = 0; i < 8; i++) begin
      src = i - int'(off);
      if (src >= 0) begin
        if (m[src]) begin
          res[i*8 +: 8] = d[src*8 +: 8];
        end
      end
    end
    return res;
  endfunction

  task automatic predict(input cpuReqT r);
    tagT        t;
    indexT      ix;
    logic [1:0] ws;
    int         hitW;
    logic       v;
    addrT       base;
    lineT       ln;
    t    = r.addr[31:11];
    ix   = r.addr[10:5];
    ws   = r.addr[4:3];
    hitW = -1;
    for (int w = 0; w < 2; w++) begin
      if (validRef[w][ix] && tagRef[w][ix] == t) begin
        hitW = w;
      end
    end
    expHit.push_back(hitW >= 0);
    if (hitW < 0) begin
      v = victimRef;
      if (validRef[v][ix] && dirtyRef[v][ix]) begin
        base = {tagRef[v][ix], ix, 5'b0};
        expWbAddr.push_back(base);
        expWbLine.push_back(lineRef[v][ix]);
        for (int k = 0; k < BeatsPerLine; k++) begin
          memRef[base + addrT'(k * 8)] = lineRef[v][ix][k*DataW +: DataW];
        end
        wbTotal++;
      end
      base = {t, ix, 5'b0};
      expRdAddr.push_back(base);
      for (int k = 0; k < BeatsPerLine; k++) begin
        ln[k*DataW +: DataW] = refWord(base + addrT'(k * 8));
      end
      lineRef[v][ix]  = ln;
      tagRef[v][ix]   = t;
      validRef[v][ix] = 1'b1;
      dirtyRef[v][ix] = 1'b0;
      victimRef       = ~victimRef;
      hitW            = int'(v);
    end
    if (r.write) begin
      lineRef[hitW][ix][ws*DataW +: DataW] =
        mergeStore(lineRef[hitW][ix][ws*DataW +: DataW], r.wdata, r.mask, r.addr[2:0]);
      dirtyRef[hitW][ix] = 1'b1;
    end
    expIsLoad.push_back(!r.write);
    expWord.push_back(lineRef[hitW][ix][ws*DataW +: DataW]);
    expAcc.push_back(cycle);
  endtask

  // first cycle of each bus request
  task automatic watchBus();
    if (wbValid && !wbSeen) begin
      if (expWbAddr.size() == 0) begin
        failPlain("write-back request that the model did not predict");
      end
      checkAddr("write-back address", wbAddr, expWbAddr.pop_front());
      checkLine("write-back line", wbLine, expWbLine.pop_front());
    end
    if (rdValid && !rdSeen) begin
      if (expWbAddr.size() != 0) begin
        failPlain("refill request came before the dirty victim was written back");
      end
      if (expRdAddr.size() == 0) begin
        failPlain("refill request that the model did not predict");
      end
      checkAddr("refill address", rdAddr, expRdAddr.pop_front());
    end
    wbSeen = wbValid;
    rdSeen = rdValid;
  endtask

  task automatic checkResponse();
    logic isLoad;
    logic isHit;
    wordT w;
    int   acc;
    if (expIsLoad.size() == 0) begin
      failPlain("dataOk pulse with no request outstanding");
    end
    isLoad = expIsLoad.pop_front();
    isHit  = expHit.pop_front();
    w      = expWord.pop_front();
    acc    = expAcc.pop_front();
    if (isHit && cycle != acc + 1) begin
      failValue($sformatf("hit answered %0d cycles after acceptance", cycle - acc));
    end
    // only a load response lets the next request in
    checkFlag("addrOk during response", addrOk, isLoad);
    if (isLoad) begin
      checkWord("load data", rdData, w);
    end
  endtask

  task automatic driveNext();
    if (opIdx < ops.size()) begin
      reqValid = 1'b1;
      req      = ops[opIdx];
    end else begin
      reqValid = 1'b0;
      req      = '0;
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    cycle     = 0;
    opIdx     = 0;
    idle      = 0;
    wbTotal   = 0;
    rdSeen    = 1'b0;
    wbSeen    = 1'b0;
    victimRef = 1'b0;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        validRef[w][s] = 1'b0;
        dirtyRef[w][s] = 1'b0;
        tagRef[w][s]   = '0;
        lineRef[w][s]  = '0;
      end
    end
    buildTable();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    checkFlag("addrOk after reset", addrOk, 1'b1);
    checkFlag("dataOk after reset", dataOk, 1'b0);
    checkFlag("rdValid after reset", rdValid, 1'b0);
    checkFlag("wbValid after reset", wbValid, 1'b0);
    @(posedge clk);
    #1;
    driveNext();
    while (opIdx < ops.size() || expIsLoad.size() > 0) begin
      @(negedge clk);
      cycle++;
      idle++;
      watchBus();
      // response of the older request before predicting a new one
      if (dataOk) begin
        checkResponse();
        idle = 0;
      end
      if (reqValid && addrOk) begin
        if (expIsLoad.size() != 0) begin
          failPlain("request accepted while an older request was still pending");
        end
        predict(ops[opIdx]);
        opIdx++;
        idle = 0;
      end
      if (idle > IdleLimit) begin
        failPlain("timeout: the cache stopped accepting or answering requests");
      end
      @(posedge clk);
      #1;
      driveNext();
    end
    if (expRdAddr.size() != 0 || expWbAddr.size() != 0) begin
      failPlain("predicted bus requests never appeared");
    end
    if (memModel_i.wbCount != wbTotal) begin
      failPlain("memory saw a different number of write-backs than predicted");
    end
    $display("No errors");
    $finish;
  end

endmodule

/* test/memModel.sv */
module memModel import dcachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic rdValid_i,
  input  addrT rdAddr_i,
  output logic rdReady_o,
  output logic beatValid_o,
  output wordT rdData_o,
  output logic rdLast_o,
  input  logic wbValid_i,
  input  addrT wbAddr_i,
  input  lineT wbLine_i,
  output logic wbReady_o
);
  timeunit 1ns;
  timeprecision 100ps;

  wordT   written [addrT];
  int     wbCount;
  integer seed;
  logic   busy, rdHs, wbHs;
  int     beatIdx;
  addrT   lineAddr, capRd, capWb;
  lineT   capLine;

  // untouched words read back as address and its complement
  function automatic wordT wordAt(addrT a);
    if (written.exists(a)) begin
      return written[a];
    end
    return {a, ~a};
  endfunction

  initial begin
    seed        = 32'hf461_b8af;
    rdReady_o   = 1'b0;
    wbReady_o   = 1'b0;
    beatValid_o = 1'b0;
    rdLast_o    = 1'b0;
    rdData_o    = '0;
    wbCount     = 0;
    busy        = 1'b0;
    beatIdx     = 0;
    lineAddr    = '0;
    forever begin
      // handshakes are decided mid-cycle and take effect at the next edge
      @(negedge clk);
      rdHs    = rst_n && rdValid_i && rdReady_o;
      wbHs    = rst_n && wbValid_i && wbReady_o;
      capRd   = rdAddr_i;
      capWb   = wbAddr_i;
      capLine = wbLine_i;
      @(posedge clk);
      #1;
      if (wbHs) begin
        for (int k = 0; k < BeatsPerLine; k++) begin
          written[capWb + addrT'(k * 8)] = capLine[k*DataW +: DataW];
        end
        wbCount++;
      end
      if (rdHs) begin
        busy     = 1'b1;
        beatIdx  = 0;
        lineAddr = capRd;
      end
      beatValid_o = 1'b0;
      rdLast_o    = 1'b0;
      // gaps between beats
      if (busy && (($random(seed) & 32'h3) != 0)) begin
        beatValid_o = 1'b1;
        rdData_o    = wordAt(lineAddr + addrT'(beatIdx * 8));
        rdLast_o    = beatIdx == BeatsPerLine - 1;
        beatIdx++;
        busy        = beatIdx < BeatsPerLine;
      end
      rdReady_o = ($random(seed) & 32'h3) != 0;
      wbReady_o = ($random(seed) & 32'h3) != 0;
    end
  end

endmodule

/* rtl/dcacheTop.sv */
module dcacheTop import dcachePkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   reqValid_i,
  input  cpuReqT req_i,
  output logic   addrOk_o,
  output logic   dataOk_o,
  output wordT   rdData_o,
  input  logic   rdReady_i,
  input  logic   beatValid_i,
  input  wordT   rdData_i,
  input  logic   rdLast_i,
  input  logic   wbReady_i,
  output logic   rdValid_o,
  output addrT   rdAddr_o,
  output logic   wbValid_o,
  output addrT   wbAddr_o,
  output lineT   wbLine_o
);

  cpuReqT     latched;
  addrFieldsT fields;
  addrFieldsT reqFields;
  storeT      store;
  cacheStateT state;
  logic       accept, storeHit, fill, missEvent, bypass;
  logic       hit, hitWay, victimWay, victimDirty;
  logic       replacing;
  tagT        victimTag;
  indexT      rdIndex;
  logic [1:0] wrEn;
  lineT       wrLine, wrMask;
  lineT       way0, way1, victimLine, refill, srcLine;

  assign reqFields = req_i.addr;
  assign replacing = state == REPLACE;

  // read the incoming index on acceptance so data is ready in COMPARE
  assign rdIndex = accept ? reqFields.index : fields.index;

  // whole refill line on replace, otherwise one store word
  assign wrEn[0] = (replacing && !victimWay) || (storeHit && !hitWay);
  assign wrEn[1] = (replacing && victimWay) || (storeHit && hitWay);
  assign wrLine  = replacing ? refill : {BeatsPerLine{store.data}};
  assign wrMask  = replacing ? '1 : lineT'(store.bitMask) << (DataW * store.wordSel);

  assign victimLine = victimWay ? way1 : way0;

  // word select over the hit way, or the refill buffer right after replace
  assign srcLine  = bypass ? refill : (hitWay ? way1 : way0);
  assign rdData_o = srcLine[fields.offset[OffsetW-1:ByteW]*DataW +: DataW];

  reqLatch reqLatch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept_i  (accept),
    .req_i     (req_i),
    .latched_o (latched),
    .fields_o  (fields),
    .store_o   (store)
  );

  tagStore tagStore_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fields_i      (fields),
    .storeHit_i    (storeHit),
    .fill_i        (fill),
    .missEvent_i   (missEvent),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore dataStore_i (
    .clk       (clk),
    .rdIndex_i (rdIndex),
    .wrIndex_i (fields.index),
    .wrEn_i    (wrEn),
    .wrLine_i  (wrLine),
    .wrMask_i  (wrMask),
    .way0_o    (way0),
    .way1_o    (way1)
  );

  cacheCtrl cacheCtrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .isStore_i     (latched.write),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .rdReady_i     (rdReady_i),
    .wbReady_i     (wbReady_i),
    .rdLast_i      (rdLast_i),
    .state_o       (state),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .accept_o      (accept),
    .storeHit_o    (storeHit),
    .fill_o        (fill),
    .missEvent_o   (missEvent),
    .bypass_o      (bypass)
  );

  busPort busPort_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state),
    .fields_i     (fields),
    .victimTag_i  (victimTag),
    .victimLine_i (victimLine),
    .rdReady_i    (rdReady_i),
    .beatValid_i  (beatValid_i),
    .rdData_i     (rdData_i),
    .wbReady_i    (wbReady_i),
    .rdValid_o    (rdValid_o),
    .rdAddr_o     (rdAddr_o),
    .wbValid_o    (wbValid_o),
    .wbAddr_o     (wbAddr_o),
    .wbLine_o     (wbLine_o),
    .refill_o     (refill)
  );

endmodule

/* rtl/busPort.sv */
module busPort import dcachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  cacheStateT state_i,
  input  addrFieldsT fields_i,
  input  tagT        victimTag_i,
  input  lineT       victimLine_i,
  input  logic       rdReady_i,
  input  logic       beatValid_i,
  input  wordT       rdData_i,
  input  logic       wbReady_i,
  output logic       rdValid_o,
  output addrT       rdAddr_o,
  output logic       wbValid_o,
  output addrT       wbAddr_o,
  output lineT       wbLine_o,
  output lineT       refill_o
);

  cacheStateT          stateQ;
  logic                entering;
  logic [WordSelW-1:0] beatCnt;

  assign entering = state_i != stateQ;

  // refill always fetches the whole line
  assign rdAddr_o = {fields_i.tag, fields_i.index, {OffsetW{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ    <= IDLE;
      rdValid_o <= 1'b0;
      wbValid_o <= 1'b0;
      beatCnt   <= '0;
    end else begin
      stateQ <= state_i;

      if ((state_i == MISS) && entering) begin
        rdValid_o <= 1'b1;
      end else if (rdValid_o && rdReady_i) begin
        rdValid_o <= 1'b0;
      end

      if ((state_i == WRBACK) && entering) begin
        wbValid_o <= 1'b1;
      end else if (wbValid_o && wbReady_i) begin
        wbValid_o <= 1'b0;
      end

      // lowest word arrives first
      if (state_i == MISS) begin
        beatCnt <= '0;
      end else if ((state_i == REFILL) && beatValid_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // snapshot of the dirty victim before it gets overwritten
    if ((state_i == WRBACK) && entering) begin
      wbLine_o <= victimLine_i;
      wbAddr_o <= {victimTag_i, fields_i.index, {OffsetW{1'b0}}};
    end
    if ((state_i == REFILL) && beatValid_i) begin
      refill_o[beatCnt*DataW +: DataW] <= rdData_i;
    end
  end

endmodule

/* rtl/cacheCtrl.sv */
module cacheCtrl import dcachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       reqValid_i,
  input  logic       isStore_i,
  input  logic       hit_i,
  input  logic       victimDirty_i,
  input  logic       rdReady_i,
  input  logic       wbReady_i,
  input  logic       rdLast_i,
  output cacheStateT state_o,
  output logic       addrOk_o,
  output logic       dataOk_o,
  output logic       accept_o,
  output logic       storeHit_o,
  output logic       fill_o,
  output logic       missEvent_o,
  output logic       bypass_o
);

  cacheStateT stateQ;
  cacheStateT stateNext;
  logic       enteredQ;
  logic       bypassQ;

  // new request only when idle or on a load hit
  assign addrOk_o = (stateQ == IDLE) || ((stateQ == COMPARE) && hit_i && !isStore_i);
  assign accept_o = reqValid_i && addrOk_o;

  always_comb begin
    stateNext = stateQ;
    case (stateQ)
      IDLE: begin
        if (accept_o) begin
          stateNext = COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          stateNext = accept_o ? COMPARE : IDLE;
        end else if (victimDirty_i) begin
          stateNext = WRBACK;
        end else begin
          stateNext = MISS;
        end
      end
      // bus request goes out one cycle after entry
      WRBACK: begin
        if (!enteredQ && wbReady_i) begin
          stateNext = MISS;
        end
      end
      MISS: begin
        if (!enteredQ && rdReady_i) begin
          stateNext = REFILL;
        end
      end
      REFILL: begin
        if (rdLast_i) begin
          stateNext = REPLACE;
        end
      end
      REPLACE: begin
        stateNext = COMPARE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ   <= IDLE;
      enteredQ <= 1'b0;
      bypassQ  <= 1'b0;
    end else begin
      stateQ   <= stateNext;
      enteredQ <= stateNext != stateQ;
      // line was written last cycle, serve the word from the buffer
      bypassQ  <= stateQ == REPLACE;
    end
  end

  assign state_o    = stateQ;
  assign bypass_o   = bypassQ;
  assign dataOk_o   = (stateQ == COMPARE) && hit_i;
  assign storeHit_o = (stateQ == COMPARE) && hit_i && isStore_i;

  // tag written with the last beat, victim flips after the line write
  assign fill_o      = (stateQ == REFILL) && rdLast_i;
  assign missEvent_o = stateQ == REPLACE;

endmodule

/* rtl/dataStore.sv */
module dataStore import dcachePkg::*; (
  input  logic       clk,
  input  indexT      rdIndex_i,
  input  indexT      wrIndex_i,
  input  logic [1:0] wrEn_i,
  input  lineT       wrLine_i,
  input  lineT       wrMask_i,
  output lineT       way0_o,
  output lineT       way1_o
);

  lineT mem [2][NumSets];
  lineT rdQ [2];

  // behavioural line store, one read and one write port per way
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wrEn_i[w]) begin
        // bits outside the mask keep their old value
        mem[w][wrIndex_i] <= (mem[w][wrIndex_i] & ~wrMask_i) | (wrLine_i & wrMask_i);
      end
      // read returns the old line on a same-index write
      rdQ[w] <= mem[w][rdIndex_i];
    end
  end

  assign way0_o = rdQ[0];
  assign way1_o = rdQ[1];

endmodule

/* rtl/tagStore.sv */
module tagStore import dcachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  addrFieldsT fields_i,
  input  logic       storeHit_i,
  input  logic       fill_i,
  input  logic       missEvent_i,
  output logic       hit_o,
  output logic       hitWay_o,
  output logic       victimWay_o,
  output logic       victimDirty_o,
  output tagT        victimTag_o
);

  tagT                       tagMem [2][NumSets];
  logic [1:0][NumSets-1:0]   validQ;
  logic [1:0][NumSets-1:0]   dirtyQ;
  logic                      victimQ;
  logic [1:0]                wayHit;
  indexT                     idx;

  assign idx = fields_i.index;

  // compare both ways against the latched tag
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][idx] && (tagMem[w][idx] == fields_i.tag);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  assign victimWay_o   = victimQ;
  assign victimDirty_o = validQ[victimQ][idx] && dirtyQ[victimQ][idx];
  assign victimTag_o   = tagMem[victimQ][idx];

  // new tag lands in the victim way once the last beat is in
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagMem[victimQ][idx] <= fields_i.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else if (fill_i) begin
      validQ[victimQ][idx] <= 1'b1;
      // freshly refilled line matches memory
      dirtyQ[victimQ][idx] <= 1'b0;
    end else if (storeHit_i) begin
      dirtyQ[hitWay_o][idx] <= 1'b1;
    end
  end

  // round robin, one flip per miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimQ <= 1'b0;
    end else if (missEvent_i) begin
      victimQ <= ~victimQ;
    end
  end

endmodule

/* rtl/reqLatch.sv */
module reqLatch import dcachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       accept_i,
  input  cpuReqT     req_i,
  output cpuReqT     latched_o,
  output addrFieldsT fields_o,
  output storeT      store_o
);

  logic [ByteW-1:0] byteOff;
  maskT             byteMask;

  // pipeline moves on after acceptance, so keep our own copy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      latched_o <= '0;
    end else if (accept_i) begin
      latched_o <= req_i;
    end
  end

  assign fields_o = latched_o.addr;

  // low address bits give the byte lane of the store
  assign byteOff  = latched_o.addr[ByteW-1:0];
  assign byteMask = latched_o.mask << byteOff;

  always_comb begin
    store_o.wordSel = latched_o.addr[OffsetW-1:ByteW];
    store_o.data    = latched_o.wdata << {byteOff, 3'b000};
    // one byte enable covers eight data bits
    for (int b = 0; b < DataW / 8; b++) begin
      store_o.bitMask[b*8 +: 8] = {8{byteMask[b]}};
    end
  end

endmodule

/* rtl/dcachePkg.sv */
package dcachePkg;

  // basic widths
  localparam int AddrW = 32;
  localparam int DataW = 64;
  localparam int LineW = 256;

  // cache geometry, two ways of 64 lines
  localparam int NumSets      = 64;
  localparam int IndexW       = 6;
  localparam int OffsetW      = 5;
  localparam int TagW         = AddrW - IndexW - OffsetW;
  localparam int BeatsPerLine = LineW / DataW;
  localparam int WordSelW     = 2;
  // byte offset inside one pipeline word
  localparam int ByteW        = 3;

  typedef logic [AddrW-1:0]   addrT;
  typedef logic [DataW-1:0]   wordT;
  typedef logic [LineW-1:0]   lineT;
  typedef logic [TagW-1:0]    tagT;
  typedef logic [IndexW-1:0]  indexT;
  typedef logic [DataW/8-1:0] maskT;

  // one request from the load/store pipeline
  typedef struct packed {
    logic write;
    addrT addr;
    wordT wdata;
    maskT mask;
  } cpuReqT;

  // address split into its cache fields
  typedef struct packed {
    tagT                 tag;
    indexT               index;
    logic [OffsetW-1:0]  offset;
  } addrFieldsT;

  // store word already shifted into place, mask widened to bits
  typedef struct packed {
    logic [WordSelW-1:0] wordSel;
    wordT                data;
    wordT                bitMask;
  } storeT;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRBACK,
    MISS,
    REFILL,
    REPLACE
  } cacheStateT;

endpackage
